// ==== traffic_gen_cfg.svh ====
`ifndef TRAFFIC_GEN_CFG_SVH
`define TRAFFIC_GEN_CFG_SVH

// stream and queue widths
`define TG_BEAT_BITS      512
`define TG_BEAT_BYTES     64
`define TG_QID_BITS       11
`define TG_CREDIT_BITS    32
`define TG_AVL_BITS       16

// fixed header fields
`define TG_DST_MAC        48'h665544332211
`define TG_SRC_MAC        48'h665544332200
`define TG_ETHERTYPE      16'h2121
`define TG_PROTOCOL       8'd6
`define TG_DST_PORT       16'd0

// frame payload
`define TG_TAIL_WORD      32'h0a212121
`define TG_FILL_BYTE      8'h41

// xorshift seeds
`define TG_SEED_DST_IP    32'h01234567
`define TG_SEED_SRC_IP    32'h89abcdef
`define TG_SEED_SRC_PORT  16'h4e5f

// toeplitz key, 40 bytes
`define TG_RSS_KEY        320'h6d5a56da255b0ec24167253d43a38fb0d0ca2bcbae7b30b477cb2da38030f20c6a42b73bbeac01fa

`endif

// ==== net_pkg.sv ====
`default_nettype none

`include "traffic_gen_cfg.svh"

package net_pkg;

   // one beat on the stream port
   typedef logic [`TG_BEAT_BITS-1:0] beat_t;

   // frame size or byte offset inside a frame
   typedef logic [15:0] byte_count_t;

   // ipv4 address
   typedef logic [31:0] ip_addr_t;

   // tcp/udp port
   typedef logic [15:0] l4_port_t;

   // receive-side-scaling hash
   typedef logic [31:0] hash_t;

endpackage

`default_nettype wire

// ==== queue_pkg.sv ====
`default_nettype none

`include "traffic_gen_cfg.svh"

package queue_pkg;

   typedef logic [`TG_QID_BITS-1:0] qid_t;

   // may go negative after an invalidate
   typedef logic signed [`TG_CREDIT_BITS-1:0] credit_t;

   typedef logic [`TG_AVL_BITS-1:0] avl_t;

   typedef enum logic [1:0] {IDLE, TRANSFER, WAIT} seq_state_t;

endpackage

`default_nettype wire

// ==== flow_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface flow_if;
   import net_pkg::*;

   // pulses on the accepted last beat of each packet
   logic     advance;
   ip_addr_t src_ip;
   ip_addr_t dst_ip;
   l4_port_t src_port;

   modport source (output advance);
   modport generator (input advance, output src_ip, output dst_ip, output src_port);
   modport user (input src_ip, input dst_ip, input src_port);

endinterface

`default_nettype wire

// ==== credit_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "traffic_gen_cfg.svh"

module credit_store (
   input  wire logic              axi_aclk,
   input  wire logic              axi_aresetn,
   input  wire logic              tm_dsc_sts_vld,
   input  wire logic              tm_dsc_sts_qen,
   input  wire logic              tm_dsc_sts_dir,
   input  wire logic              tm_dsc_sts_mm,
   input  wire logic              tm_dsc_sts_qinv,
   input  wire queue_pkg::qid_t   tm_dsc_sts_qid,
   input  wire queue_pkg::avl_t   tm_dsc_sts_avl,
   input  wire queue_pkg::qid_t   rx_qid,
   input  wire logic              consume,
   input  wire queue_pkg::qid_t   consume_qid,
   output logic                   credit_ok
);
   import queue_pkg::*;

   localparam int QUEUES = 2 ** `TG_QID_BITS;

   credit_t credit_tbl [QUEUES];
   credit_t sts_credit;
   logic    sts_upd;
   logic    cons_vld;
   logic    pend_vld;
   qid_t    cons_qid;
   qid_t    pend_qid;

   // only c2h stream queues that are enabled or invalidated count
   assign sts_upd = tm_dsc_sts_vld & tm_dsc_sts_dir & ~tm_dsc_sts_mm &
                    (tm_dsc_sts_qen | tm_dsc_sts_qinv);
   assign sts_credit = tm_dsc_sts_qinv ? credit_t'(0) :
                       credit_tbl[tm_dsc_sts_qid] + credit_t'(tm_dsc_sts_avl);

   // a deferred consume goes before a fresh one
   assign cons_vld = pend_vld | consume;
   assign cons_qid = pend_vld ? pend_qid : consume_qid;

   // status wins the write port, the consume then waits one cycle
   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         for (int q = 0; q < QUEUES; q++) begin
            credit_tbl[q] <= '0;
         end
         pend_vld <= 1'b0;
      end else begin
         if (sts_upd) begin
            credit_tbl[tm_dsc_sts_qid] <= sts_credit;
         end else if (cons_vld) begin
            credit_tbl[cons_qid] <= credit_tbl[cons_qid] - credit_t'(1);
         end
         pend_vld <= sts_upd & cons_vld;
      end
   end

   always_ff @(posedge axi_aclk) begin
      pend_qid <= cons_qid;
   end

   assign credit_ok = (credit_tbl[rx_qid] > credit_t'(0)) && !(pend_vld && pend_qid == rx_qid);

   // the sequencer must not finish a packet while the last consume is deferred
   a_no_consume_while_pending: assert property (
      @(posedge axi_aclk) disable iff (!axi_aresetn) pend_vld |-> !consume
   ) else $error("consume arrived while a deferred consume was pending");

endmodule

`default_nettype wire

// ==== frame_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "traffic_gen_cfg.svh"

module frame_sequencer (
   input  wire logic                  axi_aclk,
   input  wire logic                  axi_aresetn,
   input  wire net_pkg::byte_count_t  txr_size,
   input  wire logic [31:0]           cycles_per_pkt,
   input  wire logic                  rx_ready,
   input  wire queue_pkg::qid_t       rx_qid,
   input  wire logic                  c2h_perform,
   input  wire logic                  credit_ok,
   output logic                       rx_valid,
   output logic                       rx_last,
   output logic                       consume,
   output queue_pkg::qid_t            consume_qid,
   output logic                       first_beat,
   output logic                       tail_beat,
   flow_if.source                     flow
);
   import net_pkg::*;
   import queue_pkg::*;

   localparam byte_count_t BEAT_BYTES = byte_count_t'(`TG_BEAT_BYTES);

   seq_state_t  state;
   seq_state_t  state_nxt;
   byte_count_t size_q;
   byte_count_t offset;
   byte_count_t beats;
   qid_t        qid_q;
   logic [31:0] pace_lim;
   logic [31:0] pace_cnt;
   logic        last_beat;
   logic        accept;
   logic        pkt_done;
   logic        pace_met;
   logic        start;

   // beats per frame, partial beat rounds up
   assign beats = byte_count_t'(txr_size / BEAT_BYTES) +
                  byte_count_t'(txr_size % BEAT_BYTES != '0);

   assign last_beat = offset >= size_q - BEAT_BYTES;
   assign accept    = rx_valid & rx_ready;
   assign pkt_done  = accept & last_beat;
   assign pace_met  = pace_cnt >= pace_lim - 32'd1;
   assign start     = c2h_perform & rx_ready & credit_ok &
                      ((state == IDLE) | ((state == WAIT) & pace_met));

   assign rx_valid     = state == TRANSFER;
   assign rx_last      = rx_valid & last_beat;
   assign tail_beat    = rx_last;
   assign first_beat   = rx_valid & (offset == '0);
   assign consume      = pkt_done;
   assign consume_qid  = qid_q;
   assign flow.advance = pkt_done;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (start) begin
               state_nxt = TRANSFER;
            end
         end
         TRANSFER: begin
            if (pkt_done) begin
               state_nxt = WAIT;
            end
         end
         WAIT: begin
            if (!c2h_perform) begin
               state_nxt = IDLE;
            end else if (start) begin
               state_nxt = TRANSFER;
            end
         end
         default: state_nxt = IDLE;
      endcase
   end

   // pacing counts ready cycles from the first beat on
   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         state    <= IDLE;
         offset   <= '0;
         pace_cnt <= '0;
      end else begin
         state <= state_nxt;
         if (start) begin
            offset   <= '0;
            pace_cnt <= '0;
         end else if (rx_ready && state != IDLE) begin
            pace_cnt <= pace_cnt + 32'd1;
            if (accept && !last_beat) begin
               offset <= offset + BEAT_BYTES;
            end
         end
      end
   end

   // per-packet settings, sampled at start
   always_ff @(posedge axi_aclk) begin
      if (start) begin
         size_q   <= txr_size;
         qid_q    <= rx_qid;
         pace_lim <= (cycles_per_pkt > 32'(beats)) ? cycles_per_pkt : 32'(beats);
      end
   end

   a_last_held: assert property (
      @(posedge axi_aclk) disable iff (!axi_aresetn)
      rx_valid && !rx_ready |=> rx_valid && $stable(rx_last)
   ) else $error("rx_last changed while the beat was stalled");

endmodule

`default_nettype wire

// ==== flow_field_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "traffic_gen_cfg.svh"

module flow_field_gen (
   input  wire logic  axi_aclk,
   input  wire logic  axi_aresetn,
   flow_if.generator  flow
);
   import net_pkg::*;

   ip_addr_t dst_st;
   ip_addr_t src_st;
   l4_port_t port_st;

   // one xorshift step on a w-bit value, c is the final right shift
   function automatic logic [31:0] xorshift(input logic [31:0] x, input int w, input int c);
      logic [31:0] mask;
      logic [31:0] t;
      mask = (w >= 32) ? '1 : (32'd1 << w) - 32'd1;
      t = x ^ (x >> 7);
      t = (t ^ (t << 9)) & mask;
      return t ^ (t >> c);
   endfunction

   assign flow.dst_ip   = ip_addr_t'(xorshift(dst_st, 32, 13));
   assign flow.src_ip   = ip_addr_t'(xorshift(src_st, 32, 13));
   assign flow.src_port = l4_port_t'(xorshift(32'(port_st), 16, 8));

   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         dst_st  <= `TG_SEED_DST_IP;
         src_st  <= `TG_SEED_SRC_IP;
         port_st <= `TG_SEED_SRC_PORT;
      end else if (flow.advance) begin
         dst_st  <= flow.dst_ip;
         src_st  <= flow.src_ip;
         port_st <= flow.src_port;
      end
   end

endmodule

`default_nettype wire

// ==== beat_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "traffic_gen_cfg.svh"

module beat_builder (
   input  wire logic        first_beat,
   input  wire logic        tail_beat,
   output net_pkg::beat_t   rx_data,
   flow_if.user             flow
);
   // ethernet + ip + transport, 54 bytes
   localparam int HDR_BITS = 432;

   logic [111:0] eth_hdr;
   logic [159:0] ip_hdr;
   logic [159:0] l4_hdr;

   // no length field in the ethernet part
   assign eth_hdr = {`TG_DST_MAC, `TG_SRC_MAC, `TG_ETHERTYPE};
   assign ip_hdr  = {72'b0, `TG_PROTOCOL, 16'b0, flow.src_ip, flow.dst_ip};
   assign l4_hdr  = {flow.src_port, `TG_DST_PORT, 128'b0};

   always_comb begin
      rx_data = {`TG_BEAT_BYTES{`TG_FILL_BYTE}};
      // headers sit at the top of the first beat
      if (first_beat) begin
         rx_data[`TG_BEAT_BITS-1 -: HDR_BITS] = {eth_hdr, ip_hdr, l4_hdr};
      end
      if (tail_beat) begin
         rx_data[31:0] = `TG_TAIL_WORD;
      end
   end

endmodule

`default_nettype wire

// ==== rss_hash.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "traffic_gen_cfg.svh"

module rss_hash (
   input  wire logic        axi_aclk,
   output net_pkg::hash_t   hash_val,
   flow_if.user             flow
);
   import net_pkg::*;

   localparam logic [319:0] RSS_KEY    = `TG_RSS_KEY;
   localparam int           KEY_TOP    = 320 - 32;
   localparam int           TUPLE_BITS = 104;

   logic [TUPLE_BITS-1:0] tuple_q;
   hash_t                 hash_nxt;

   // stage one holds the tuple, stage two the hash
   always_ff @(posedge axi_aclk) begin
      tuple_q  <= {flow.src_ip, flow.dst_ip, flow.src_port, `TG_DST_PORT, `TG_PROTOCOL};
      hash_val <= hash_nxt;
   end

   // key window slides one bit per tuple bit
   always_comb begin
      hash_nxt = '0;
      for (int i = 0; i < TUPLE_BITS; i++) begin
         if (tuple_q[i]) begin
            hash_nxt ^= RSS_KEY[KEY_TOP - i +: 32];
         end
      end
   end

endmodule

`default_nettype wire

// ==== traffic_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module traffic_gen (
   input  wire logic                  axi_aclk,
   input  wire logic                  axi_aresetn,
   input  wire net_pkg::byte_count_t  txr_size,
   input  wire logic [31:0]           cycles_per_pkt,
   input  wire logic                  rx_ready,
   input  wire queue_pkg::qid_t       rx_qid,
   input  wire logic                  c2h_perform,
   input  wire logic                  tm_dsc_sts_vld,
   input  wire logic                  tm_dsc_sts_qen,
   input  wire logic                  tm_dsc_sts_dir,
   input  wire logic                  tm_dsc_sts_mm,
   input  wire logic                  tm_dsc_sts_qinv,
   input  wire queue_pkg::qid_t       tm_dsc_sts_qid,
   input  wire queue_pkg::avl_t       tm_dsc_sts_avl,
   output logic                       rx_valid,
   output logic                       rx_last,
   output net_pkg::beat_t             rx_data,
   output net_pkg::hash_t             hash_val
);
   import queue_pkg::*;

   logic credit_ok;
   logic consume;
   qid_t consume_qid;
   logic first_beat;
   logic tail_beat;

   flow_if flow ();

   credit_store i_credit_store (
      .axi_aclk        (axi_aclk),
      .axi_aresetn     (axi_aresetn),
      .tm_dsc_sts_vld  (tm_dsc_sts_vld),
      .tm_dsc_sts_qen  (tm_dsc_sts_qen),
      .tm_dsc_sts_dir  (tm_dsc_sts_dir),
      .tm_dsc_sts_mm   (tm_dsc_sts_mm),
      .tm_dsc_sts_qinv (tm_dsc_sts_qinv),
      .tm_dsc_sts_qid  (tm_dsc_sts_qid),
      .tm_dsc_sts_avl  (tm_dsc_sts_avl),
      .rx_qid          (rx_qid),
      .consume         (consume),
      .consume_qid     (consume_qid),
      .credit_ok       (credit_ok)
   );

   frame_sequencer i_frame_sequencer (
      .axi_aclk       (axi_aclk),
      .axi_aresetn    (axi_aresetn),
      .txr_size       (txr_size),
      .cycles_per_pkt (cycles_per_pkt),
      .rx_ready       (rx_ready),
      .rx_qid         (rx_qid),
      .c2h_perform    (c2h_perform),
      .credit_ok      (credit_ok),
      .rx_valid       (rx_valid),
      .rx_last        (rx_last),
      .consume        (consume),
      .consume_qid    (consume_qid),
      .first_beat     (first_beat),
      .tail_beat      (tail_beat),
      .flow           (flow)
   );

   flow_field_gen i_flow_field_gen (
      .axi_aclk    (axi_aclk),
      .axi_aresetn (axi_aresetn),
      .flow        (flow)
   );

   beat_builder i_beat_builder (
      .first_beat (first_beat),
      .tail_beat  (tail_beat),
      .rx_data    (rx_data),
      .flow       (flow)
   );

   rss_hash i_rss_hash (
      .axi_aclk (axi_aclk),
      .hash_val (hash_val),
      .flow     (flow)
   );

endmodule

`default_nettype wire

// ==== tb_traffic_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "traffic_gen_cfg.svh"

module tb_traffic_gen;
   import net_pkg::*;
   import queue_pkg::*;

   localparam int QUEUES = 2 ** `TG_QID_BITS;

   logic        axi_aclk;
   logic        axi_aresetn;
   byte_count_t txr_size;
   logic [31:0] cycles_per_pkt;
   logic        rx_ready;
   qid_t        rx_qid;
   logic        c2h_perform;
   logic        tm_dsc_sts_vld;
   logic        tm_dsc_sts_qen;
   logic        tm_dsc_sts_dir;
   logic        tm_dsc_sts_mm;
   logic        tm_dsc_sts_qinv;
   qid_t        tm_dsc_sts_qid;
   avl_t        tm_dsc_sts_avl;
   logic        rx_valid;
   logic        rx_last;
   beat_t       rx_data;
   hash_t       hash_val;

   // per queue credit model is granted minus used
   credit_t     credit_base [QUEUES] = '{default: '0};
   credit_t     credit_used [QUEUES] = '{default: '0};

   // stimulus side
   logic        ready_random = 1'b0;
   logic        pace_on = 1'b0;
   int          tb_errors = 0;
   int          tests_failed = 0;
   int          err_mark;
   int          mark;
   int          base;
   int          k;
   qid_t        queue_id;

   // monitor side
   int          cycle = 0;
   int          mon_errors = 0;
   int          pkt_count = 0;
   int          valid_cycles = 0;
   int          hash_checks = 0;
   int          pace_checks = 0;
   hash_t       hash_exp;
   hash_t       hash_exp_q [$];
   int          hash_due_q [$];
   ip_addr_t    src_st = `TG_SEED_SRC_IP;
   ip_addr_t    dst_st = `TG_SEED_DST_IP;
   l4_port_t    port_st = `TG_SEED_SRC_PORT;
   ip_addr_t    cur_src;
   ip_addr_t    cur_dst;
   l4_port_t    cur_port;
   logic        in_pkt = 1'b0;
   int          beat_idx = 0;
   byte_count_t pkt_size;
   qid_t        pkt_qid;
   logic        is_last;
   beat_t       exp_data;
   logic        stalled = 1'b0;
   beat_t       held_data;
   logic        held_last;
   logic        have_prev = 1'b0;
   int          last_first;
   int          last_p;
   int          last_n;
   byte_count_t prev_size;
   logic [31:0] prev_cpp;
   qid_t        prev_qid;

   traffic_gen i_traffic_gen (
      .axi_aclk        (axi_aclk),
      .axi_aresetn     (axi_aresetn),
      .txr_size        (txr_size),
      .cycles_per_pkt  (cycles_per_pkt),
      .rx_ready        (rx_ready),
      .rx_qid          (rx_qid),
      .c2h_perform     (c2h_perform),
      .tm_dsc_sts_vld  (tm_dsc_sts_vld),
      .tm_dsc_sts_qen  (tm_dsc_sts_qen),
      .tm_dsc_sts_dir  (tm_dsc_sts_dir),
      .tm_dsc_sts_mm   (tm_dsc_sts_mm),
      .tm_dsc_sts_qinv (tm_dsc_sts_qinv),
      .tm_dsc_sts_qid  (tm_dsc_sts_qid),
      .tm_dsc_sts_avl  (tm_dsc_sts_avl),
      .rx_valid        (rx_valid),
      .rx_last         (rx_last),
      .rx_data         (rx_data),
      .hash_val        (hash_val)
   );

   initial begin
      axi_aclk = 1'b0;
      forever #50 axi_aclk = ~axi_aclk;
   end

   function automatic ip_addr_t step32(input ip_addr_t x);
      ip_addr_t v;
      v = x ^ (x >> 7);
      v = v ^ (v << 9);
      return v ^ (v >> 13);
   endfunction

   function automatic l4_port_t step16(input l4_port_t x);
      l4_port_t v;
      v = x ^ (x >> 7);
      v = v ^ (v << 9);
      return v ^ (v >> 8);
   endfunction

   function automatic hash_t toeplitz(input ip_addr_t sip, input ip_addr_t dip,
                                      input l4_port_t sp);
      logic [103:0] tuple;
      logic [319:0] key;
      hash_t        h;
      tuple = {sip, dip, sp, `TG_DST_PORT, `TG_PROTOCOL};
      key = `TG_RSS_KEY;
      h = '0;
      // tuple bit i selects the key window whose low end is key bit 288 - i
      for (int i = 0; i < 104; i++) begin
         if (tuple[i]) begin
            h = h ^ 32'(key >> (288 - i));
         end
      end
      return h;
   endfunction

   function automatic beat_t expected_beat(input logic head, input logic tail);
      beat_t        b;
      logic [431:0] hdr;
      b = {`TG_BEAT_BYTES{`TG_FILL_BYTE}};
      // ethernet, ip, transport
      hdr = {`TG_DST_MAC, `TG_SRC_MAC, `TG_ETHERTYPE,
             72'b0, `TG_PROTOCOL, 16'b0, cur_src, cur_dst,
             cur_port, `TG_DST_PORT, 128'b0};
      if (head) begin
         b[`TG_BEAT_BITS-1 -: 432] = hdr;
      end
      if (tail) begin
         b[31:0] = `TG_TAIL_WORD;
      end
      return b;
   endfunction

   function automatic int total_errors();
      return tb_errors + mon_errors;
   endfunction

   task automatic print_fail(input string msg);
      $display("Fail at time %0t: %s", $time, msg);
   endtask

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Checks failed");
      $finish;
   endtask

   task automatic tick();
      @(posedge axi_aclk);
      #1;
      rx_ready = ready_random ? (($urandom % 4) != 0) : 1'b1;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) tick();
   endtask

   task automatic send_status(input logic qen, input logic dir, input logic mm,
                              input logic qinv, input qid_t qid, input avl_t avl);
      tick();
      tm_dsc_sts_vld  = 1'b1;
      tm_dsc_sts_qen  = qen;
      tm_dsc_sts_dir  = dir;
      tm_dsc_sts_mm   = mm;
      tm_dsc_sts_qinv = qinv;
      tm_dsc_sts_qid  = qid;
      tm_dsc_sts_avl  = avl;
      // only c2h stream beats with qen or qinv count
      if (dir && !mm && (qen || qinv)) begin
         if (qinv) begin
            credit_base[qid] = credit_used[qid];
         end else begin
            credit_base[qid] = credit_base[qid] + credit_t'(avl);
         end
      end
      tick();
      tm_dsc_sts_vld = 1'b0;
   endtask

   task automatic wait_packets(input int target, input int limit, input string what);
      int n;
      n = 0;
      while (pkt_count < target && n < limit) begin
         tick();
         n++;
      end
      if (pkt_count < target) begin
         abort_run($sformatf("Timeout after %0d cycles waiting for %s", limit, what));
      end
   endtask

   task automatic check_idle(input string what);
      mark = valid_cycles;
      idle_cycles(50);
      if (valid_cycles != mark) begin
         print_fail($sformatf("rx_valid seen %s", what));
         tb_errors++;
      end
   endtask

   task automatic check_packets(input int expected);
      if (pkt_count != expected) begin
         print_fail($sformatf("expected %0d packets, saw %0d", expected, pkt_count));
         tb_errors++;
      end
   endtask

   task automatic finish_test(input int num, input string name, input int err_start);
      int errs;
      errs = total_errors() - err_start;
      if (errs == 0) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d errors", num, name, errs);
         tests_failed++;
      end
   endtask

   // latch per-packet settings from the start cycle and step the flow model
   task automatic open_packet();
      int n;
      int p;
      int gap;
      in_pkt   = 1'b1;
      beat_idx = 0;
      pkt_size = prev_size;
      pkt_qid  = prev_qid;
      n = (int'(prev_size) + `TG_BEAT_BYTES - 1) / `TG_BEAT_BYTES;
      p = (int'(prev_cpp) > n) ? int'(prev_cpp) : n;
      if (credit_base[pkt_qid] - credit_used[pkt_qid] <= 0) begin
         print_fail($sformatf("packet started on queue %0d without credit", pkt_qid));
         mon_errors++;
      end
      credit_used[pkt_qid] = credit_used[pkt_qid] + credit_t'(1);
      cur_src  = step32(src_st);
      cur_dst  = step32(dst_st);
      cur_port = step16(port_st);
      if (pace_on && have_prev) begin
         gap = (last_p > last_n + 1) ? last_p : last_n + 1;
         pace_checks++;
         if (cycle - last_first != gap) begin
            print_fail($sformatf("first beats %0d cycles apart, expected %0d",
                                 cycle - last_first, gap));
            mon_errors++;
         end
      end
      have_prev  = 1'b1;
      last_first = cycle;
      last_p     = p;
      last_n     = n;
   endtask

   // monitor samples outputs on the falling edge
   always @(negedge axi_aclk) begin
      cycle = cycle + 1;
      if (hash_due_q.size() > 0 && hash_due_q[0] == cycle) begin
         hash_exp = hash_exp_q.pop_front();
         hash_due_q.delete(0);
         hash_checks++;
         if (hash_val !== hash_exp) begin
            print_fail($sformatf("hash_val %08h, expected %08h", hash_val, hash_exp));
            mon_errors++;
         end
      end
      if (!pace_on) begin
         have_prev = 1'b0;
      end
      if (axi_aresetn) begin
         if (stalled && (!rx_valid || rx_data !== held_data || rx_last !== held_last)) begin
            print_fail("beat changed while rx_ready was low");
            mon_errors++;
         end
         if (rx_valid) begin
            valid_cycles++;
            if (!in_pkt) begin
               open_packet();
            end
            is_last  = (beat_idx * `TG_BEAT_BYTES + `TG_BEAT_BYTES) >= int'(pkt_size);
            exp_data = expected_beat(beat_idx == 0, is_last);
            if (rx_last !== is_last) begin
               print_fail($sformatf("rx_last %0b on beat %0d of %0d bytes",
                                    rx_last, beat_idx, pkt_size));
               mon_errors++;
            end
            if (rx_data !== exp_data) begin
               print_fail($sformatf("rx_data wrong on beat %0d", beat_idx));
               mon_errors++;
            end
            if (rx_ready) begin
               if (is_last) begin
                  in_pkt  = 1'b0;
                  pkt_count++;
                  src_st  = cur_src;
                  dst_st  = cur_dst;
                  port_st = cur_port;
                  // fields step on the coming edge and hash_val two edges after that
                  hash_exp_q.push_back(toeplitz(step32(src_st), step32(dst_st),
                                                step16(port_st)));
                  hash_due_q.push_back(cycle + 3);
               end else begin
                  beat_idx++;
               end
            end
         end
         stalled   = rx_valid && !rx_ready;
         held_data = rx_data;
         held_last = rx_last;
      end
      prev_size = txr_size;
      prev_cpp  = cycles_per_pkt;
      prev_qid  = rx_qid;
   end

   initial begin
      void'($urandom(32'h534e_9f6d));
      axi_aresetn     = 1'b0;
      txr_size        = byte_count_t'(128);
      cycles_per_pkt  = 32'd0;
      rx_ready        = 1'b0;
      rx_qid          = '0;
      c2h_perform     = 1'b0;
      tm_dsc_sts_vld  = 1'b0;
      tm_dsc_sts_qen  = 1'b0;
      tm_dsc_sts_dir  = 1'b0;
      tm_dsc_sts_mm   = 1'b0;
      tm_dsc_sts_qinv = 1'b0;
      tm_dsc_sts_qid  = '0;
      tm_dsc_sts_avl  = '0;
      repeat (8) tick();
      axi_aresetn = 1'b1;
      queue_id = qid_t'($urandom % QUEUES);

      // credit gating
      err_mark    = total_errors();
      rx_qid      = queue_id;
      c2h_perform = 1'b1;
      check_idle("with zero credit");
      k    = 2 + $urandom % 4;
      base = pkt_count;
      send_status(1'b1, 1'b1, 1'b0, 1'b0, queue_id, avl_t'(k));
      wait_packets(base + k, 500, "credited packets");
      idle_cycles(50);
      check_packets(base + k);
      finish_test(1, "credit gating", err_mark);

      // invalidate and then beats that must be ignored
      err_mark    = total_errors();
      c2h_perform = 1'b0;
      send_status(1'b1, 1'b1, 1'b0, 1'b0, queue_id, avl_t'(3));
      send_status(1'b0, 1'b1, 1'b0, 1'b1, queue_id, avl_t'(0));
      send_status(1'b1, 1'b0, 1'b0, 1'b0, queue_id, avl_t'(5));
      send_status(1'b1, 1'b1, 1'b1, 1'b0, queue_id, avl_t'(5));
      tick();
      c2h_perform = 1'b1;
      check_idle("after invalidate");
      base = pkt_count;
      send_status(1'b1, 1'b1, 1'b0, 1'b0, queue_id, avl_t'(1));
      wait_packets(base + 1, 500, "packet after invalidate");
      idle_cycles(50);
      check_packets(base + 1);
      finish_test(2, "queue invalidate", err_mark);

      // random frame sizes
      err_mark = total_errors();
      send_status(1'b1, 1'b1, 1'b0, 1'b0, queue_id, avl_t'(200));
      for (int i = 0; i < 12; i++) begin
         txr_size       = byte_count_t'(64 + $urandom % 961);
         cycles_per_pkt = $urandom % 4;
         wait_packets(pkt_count + 1, 2000, "framed packets");
      end
      finish_test(3, "frame content", err_mark);

      err_mark     = total_errors();
      ready_random = 1'b1;
      for (int i = 0; i < 12; i++) begin
         txr_size = byte_count_t'(64 + $urandom % 961);
         wait_packets(pkt_count + 1, 2000, "packets under back-pressure");
      end
      finish_test(4, "back-pressure", err_mark);

      // pacing needs rx_ready high for whole packets
      err_mark     = total_errors();
      ready_random = 1'b0;
      wait_packets(pkt_count + 1, 2000, "last back-pressured packet");
      pace_on = 1'b1;
      mark    = pace_checks;
      for (int i = 0; i < 10; i++) begin
         cycles_per_pkt = 2 + $urandom % 20;
         txr_size       = byte_count_t'(64 + $urandom % 449);
         wait_packets(pkt_count + 1, 2000, "paced packets");
      end
      pace_on = 1'b0;
      if (pace_checks - mark < 8) begin
         print_fail($sformatf("only %0d packet gaps measured", pace_checks - mark));
         tb_errors++;
      end
      finish_test(5, "pacing", err_mark);

      err_mark     = total_errors();
      ready_random = 1'b1;
      mark         = hash_checks;
      for (int i = 0; i < 8; i++) begin
         cycles_per_pkt = $urandom % 8;
         txr_size       = byte_count_t'(64 + $urandom % 961);
         wait_packets(pkt_count + 1, 2000, "flow packets");
      end
      idle_cycles(4);
      if (hash_checks - mark < 7) begin
         print_fail($sformatf("only %0d hash values compared", hash_checks - mark));
         tb_errors++;
      end
      finish_test(6, "flow and hash", err_mark);

      c2h_perform = 1'b0;
      idle_cycles(40);
      $display("tests 6, failing tests %0d, packets %0d, hash checks %0d, errors %0d",
               tests_failed, pkt_count, hash_checks, total_errors());
      if (total_errors() == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
net_pkg.sv
queue_pkg.sv
flow_if.sv
credit_store.sv
frame_sequencer.sv
flow_field_gen.sv
beat_builder.sv
rss_hash.sv
traffic_gen.sv
tb_traffic_gen.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_traffic_gen
SEED_FLAGS ?=
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f sim.f
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SEED_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(BUILD_DIR)
